// File: privTrapStim.txt
// Seven hex words per record: op a b c d e f. Op 1 write: csr data bresp. Op 2 read: csr
// rdata rresp hold. Op 3 retire: ctrl iaddr daddr instr flags(trap 0, ret 1, mode 5:4) pc
// Reset state and bus basics
2 00000300 00000000 0 0 0 0
2 00000304 00000000 0 0 0 0
2 00000342 00000000 0 0 0 0
2 000007c0 00000000 2 1 0 0
1 00000305 00000103 0 0 0 0
2 00000305 00000100 0 3 0 0
1 00000105 00000200 0 0 0 0
1 000007c0 12345678 2 0 0 0
3 00000000 00001000 00000000 00000000 30 00000100
// Exception priority, tval and ecall from M
3 000000cc 00002000 00000000 0badc0de 31 00000100
2 00000342 00000002 0 0 0 0
2 00000341 00002000 0 0 0 0
2 00000343 0badc0de 0 0 0 0
2 00000300 00001800 0 0 0 0
3 00010100 00002004 00000000 00000000 31 00000100
2 00000342 0000000b 0 0 0 0
2 00000343 00000000 0 0 0 0
3 00000021 00003002 00000005 00000000 31 00000100
2 00000342 00000000 0 0 0 0
2 00000343 00003002 0 0 0 0
// mret into U with MIE restored
1 00000300 00000080 0 0 0 0
1 00000341 00004000 0 0 0 0
3 00001000 00004100 00000000 00000000 32 00004000
2 00000300 00000088 0 0 0 0
// Machine interrupts outrank faults, then wait for mret
1 00000304 00000880 0 0 0 0
4 00000006 0 0 0 0 0
3 00000004 00005000 00000000 00000013 01 00000100
2 00000342 8000000b 0 0 0 0
2 00000341 00005000 0 0 0 0
2 00000343 00000000 0 0 0 0
2 00000300 00000080 0 0 0 0
3 00000000 00005004 00000000 00000000 30 00000100
3 00001000 00005008 00000000 00000000 32 00005000
3 00000000 00006000 00000000 00000000 01 00000100
4 00000000 0 0 0 0 0
// Delegation to S and sret
1 00000302 00000004 0 0 0 0
3 00001000 00006100 00000000 00000000 32 00006000
3 00000004 00007000 00000000 0000ffff 01 00000200
2 00000142 00000002 0 0 0 0
2 00000141 00007000 0 0 0 0
2 00000143 0000ffff 0 0 0 0
1 00000100 00000120 0 0 0 0
1 00000141 00008000 0 0 0 0
3 00002000 00007100 00000000 00000000 12 00008000
2 00000100 00000022 0 0 0 0
3 00000004 00009000 00000000 00000000 11 00000200
3 00010100 00009004 00000000 00000000 11 00000100
2 00000342 00000009 0 0 0 0
2 00000341 00009004 0 0 0 0
3 00000004 0000a000 00000000 00000000 31 00000100
2 00000342 00000002 0 0 0 0
// Writable bits under back-pressure
1 00000303 ffffffff 0 0 0 0
2 00000303 00000222 0 4 0 0
1 00000304 ffffffff 0 0 0 0
2 00000304 00000aaa 0 2 0 0

// File: privTrapTop.f
privPkg.sv
trapCause.sv
trapRoute.sv
privCsrFile.sv
csrAxiLite.sv
privTrapTop.sv
tbPrivTrap.sv

// File: Makefile
# Verilator build and run of the trap subsystem testbench
TOP = tbPrivTrap

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f privTrapTop.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tbPrivTrap.sv
// Testbench for the trap subsystem, replaying CSR bus and retire records from a stim file
`timescale 1ns/1ps
`default_nettype none

module tbPrivTrap import privPkg::*; ();

  localparam int clkPeriod = 20;
  localparam int recWords  = 7;
  localparam int maxRecs   = 128;
  localparam int respWait  = 20;

  logic                  clk;
  logic                  reset;
  logic                  retire;
  logic [faultCount-1:0] faults;
  logic                  mret;
  logic                  sret;
  logic [XLEN-1:0]       instrAddr;
  logic [XLEN-1:0]       dataAddr;
  logic [31:0]           instr;
  logic                  extIntM;
  logic                  timerIntM;
  logic                  softIntM;
  logic                  trapTaken;
  logic                  retTaken;
  logic [XLEN-1:0]       redirectPc;
  logic [1:0]            mode;
  logic [XLEN-1:0]       awaddr;
  logic                  awvalid;
  logic                  awready;
  logic [XLEN-1:0]       wdata;
  logic                  wvalid;
  logic                  wready;
  logic [1:0]            bresp;
  logic                  bvalid;
  logic                  bready;
  logic [XLEN-1:0]       araddr;
  logic                  arvalid;
  logic                  arready;
  logic [XLEN-1:0]       rdata;
  logic [1:0]            rresp;
  logic                  rvalid;
  logic                  rready;

  // Flat record memory, recWords words per stim line
  logic [31:0] stim [0:recWords*maxRecs-1];
  int          recCount;
  int          errorCount;
  int          checkCount;
  int          watchCycles;
  integer      seed;
  logic        watchArmed;

  initial begin
    clk = 1'b0;
    forever #(clkPeriod/2) clk = ~clk;
  end

  privTrapTop u_privTrapTop (
    .clk, .reset, .retire, .faults, .mret, .sret, .instrAddr, .dataAddr, .instr,
    .extIntM, .timerIntM, .softIntM, .trapTaken, .retTaken, .redirectPc, .mode,
    .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready, .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
  );

  //////////////////////////////////////////////////
  // Checking and bus tasks
  //////////////////////////////////////////////////
  task automatic checkValue(input string name, input logic [31:0] expVal,
                            input logic [31:0] gotVal);
    checkCount++;
    assert (gotVal === expVal)
      else begin
        errorCount++;
        $display("FAILED %s expected %h actual %h", name, expVal, gotVal);
      end
  endtask

  task automatic busWrite(input int idx, input logic [11:0] csr, input logic [31:0] data,
                          input logic [1:0] expResp);
    int waitCycles;
    @(negedge clk);
    awaddr     = {18'd0, csr, 2'b00};
    awvalid    = 1'b1;
    wdata      = data;
    wvalid     = 1'b1;
    waitCycles = 0;
    // Nothing pending, both channels ready in the same cycle
    #(clkPeriod/4);
    checkValue($sformatf("rec%0d write %h awready", idx, csr), 32'd1, 32'(awready));
    checkValue($sformatf("rec%0d write %h wready", idx, csr), 32'd1, 32'(wready));
    // bvalid rising marks the edge that took the write
    do begin
      @(negedge clk);
      waitCycles++;
    end while (!bvalid && waitCycles < respWait);
    // Held response blocks a second write
    checkValue($sformatf("rec%0d write %h awready low", idx, csr), 32'd0, 32'(awready));
    checkValue($sformatf("rec%0d write %h wready low", idx, csr), 32'd0, 32'(wready));
    awvalid = 1'b0;
    wvalid  = 1'b0;
    assert (bvalid)
      else begin
        errorCount++;
        $display("Bus write to CSR %h in record %0d got no response", csr, idx);
      end
    checkValue($sformatf("rec%0d write %h bresp", idx, csr), 32'(expResp), 32'(bresp));
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic busRead(input int idx, input logic [11:0] csr, input logic [31:0] expData,
                         input logic [1:0] expResp, input int holdCycles);
    int          waitCycles;
    logic [31:0] firstData;
    logic [1:0]  firstResp;
    @(negedge clk);
    araddr     = {18'd0, csr, 2'b00};
    arvalid    = 1'b1;
    rready     = 1'b0;
    waitCycles = 0;
    #(clkPeriod/4);
    checkValue($sformatf("rec%0d read %h arready", idx, csr), 32'd1, 32'(arready));
    do begin
      @(negedge clk);
      waitCycles++;
    end while (!rvalid && waitCycles < respWait);
    // Held response blocks a second read
    checkValue($sformatf("rec%0d read %h arready low", idx, csr), 32'd0, 32'(arready));
    arvalid = 1'b0;
    assert (rvalid)
      else begin
        errorCount++;
        $display("Bus read of CSR %h in record %0d got no response", csr, idx);
      end
    firstData = rdata;
    firstResp = rresp;
    // Back-pressure, response must sit still
    repeat (holdCycles) begin
      @(negedge clk);
      checkValue($sformatf("rec%0d read %h held rvalid", idx, csr), 32'd1, 32'(rvalid));
      checkValue($sformatf("rec%0d read %h held rdata", idx, csr), firstData, rdata);
    end
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
    checkValue($sformatf("rec%0d read %h rvalid drop", idx, csr), 32'd0, 32'(rvalid));
    checkValue($sformatf("rec%0d read %h rdata", idx, csr), expData, firstData);
    checkValue($sformatf("rec%0d read %h rresp", idx, csr), 32'(expResp), 32'(firstResp));
  endtask

  // ctrl holds faults in 11:0, mret 12, sret 13, random fill 16
  task automatic retireOp(input int idx, input logic [31:0] ctrl, input logic [31:0] iAddr,
                          input logic [31:0] dAddr, input logic [31:0] iWord,
                          input logic [5:0] expFlags, input logic [31:0] expPc);
    @(negedge clk);
    retire    = 1'b1;
    faults    = ctrl[faultCount-1:0];
    mret      = ctrl[12];
    sret      = ctrl[13];
    instrAddr = iAddr;
    if (ctrl[16]) begin
      instr    = $random(seed);
      dataAddr = $random(seed);
    end else begin
      instr    = iWord;
      dataAddr = dAddr;
    end
    // Outputs are combinational, look well before the rising edge
    #(clkPeriod/4);
    checkValue($sformatf("rec%0d trapTaken", idx), 32'(expFlags[0]), 32'(trapTaken));
    checkValue($sformatf("rec%0d retTaken", idx), 32'(expFlags[1]), 32'(retTaken));
    checkValue($sformatf("rec%0d mode", idx), 32'(expFlags[5:4]), 32'(mode));
    checkValue($sformatf("rec%0d redirectPc", idx), expPc, redirectPc);
    @(negedge clk);
    retire = 1'b0;
    faults = '0;
    mret   = 1'b0;
    sret   = 1'b0;
  endtask

  task automatic irqOp(input logic [2:0] lines);
    @(negedge clk);
    softIntM  = lines[0];
    timerIntM = lines[1];
    extIntM   = lines[2];
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    int rec;
    int base;
    reset      = 1'b1;
    retire     = 1'b0;
    faults     = '0;
    mret       = 1'b0;
    sret       = 1'b0;
    instrAddr  = '0;
    dataAddr   = '0;
    instr      = '0;
    extIntM    = 1'b0;
    timerIntM  = 1'b0;
    softIntM   = 1'b0;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    seed       = 28;
    errorCount = 0;
    checkCount = 0;
    recCount   = 0;
    for (rec = 0; rec < recWords*maxRecs; rec++) begin
      stim[rec] = '0;
    end
    $readmemh("privTrapStim.txt", stim);
    // Operation code zero ends the list
    while (recCount < maxRecs && stim[recCount*recWords] != 0) begin
      recCount++;
    end
    watchCycles = 16 + 40 * recCount;
    watchArmed  = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (rec = 0; rec < recCount; rec++) begin
      base = rec * recWords;
      case (stim[base])
        1: busWrite(rec, stim[base+1][11:0], stim[base+2], stim[base+3][1:0]);
        2: busRead(rec, stim[base+1][11:0], stim[base+2], stim[base+3][1:0], stim[base+4]);
        3: retireOp(rec, stim[base+1], stim[base+2], stim[base+3], stim[base+4],
                    stim[base+5][5:0], stim[base+6]);
        4: irqOp(stim[base+1][2:0]);
        default: begin
          errorCount++;
          $display("Record %0d has unknown operation %h", rec, stim[base]);
        end
      endcase
    end
    repeat (2) @(negedge clk);
    $display("Records: %0d, checks: %0d, errors: %0d", recCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog sized from the record count
  initial begin
    wait (watchArmed);
    repeat (watchCycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles before the records finished", watchCycles);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: privTrapTop.sv
// Trap subsystem top joining trap decision, mode routing, CSR file and AXI4-Lite port
`timescale 1ns/1ps
`default_nettype none

module privTrapTop import privPkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  // Retire interface
  input  logic                  retire,
  input  logic [faultCount-1:0] faults,
  input  logic                  mret,
  input  logic                  sret,
  input  logic [XLEN-1:0]       instrAddr,
  input  logic [XLEN-1:0]       dataAddr,
  input  logic [31:0]           instr,
  // Machine interrupt lines
  input  logic                  extIntM,
  input  logic                  timerIntM,
  input  logic                  softIntM,
  // Trap outputs
  output logic                  trapTaken,
  output logic                  retTaken,
  output logic [XLEN-1:0]       redirectPc,
  output logic [1:0]            mode,
  // AXI4-Lite CSR port
  input  logic [XLEN-1:0]       awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [XLEN-1:0]       wdata,
  input  logic                  wvalid,
  output logic                  wready,
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready,
  input  logic [XLEN-1:0]       araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [XLEN-1:0]       rdata,
  output logic [1:0]            rresp,
  output logic                  rvalid,
  input  logic                  rready
);

  logic            trap, mTrap, sTrap, ret;
  logic            mretGo, sretGo;
  logic [1:0]      nextMode;
  logic [XLEN-1:0] cause, tval;
  logic [XLEN-1:0] mtvec, stvec, mepc, sepc;
  logic [XLEN-1:0] medeleg, mideleg;
  logic [11:0]     mie, mip;
  logic            statusMie, statusSie, spp;
  logic [1:0]      mpp;
  logic [11:0]     csrAddr;
  logic            csrWrite, csrRead, csrValid;
  logic [XLEN-1:0] csrWdata, csrRdata;

  // Returns that actually retire without a trap
  assign mretGo    = ret && mret;
  assign sretGo    = ret && sret;
  assign trapTaken = trap;
  assign retTaken  = ret;

  trapCause u_trapCause (
    .reset, .retire, .faults, .mret, .sret, .mode, .nextMode, .mip, .mie,
    .statusMie, .statusSie, .instrAddr, .dataAddr, .instr,
    .mtvec, .stvec, .mepc, .sepc,
    .trap, .mTrap, .sTrap, .ret, .cause, .tval, .redirectPc
  );

  trapRoute u_trapRoute (
    .clk, .reset, .trap, .ret, .mret(mretGo), .cause, .medeleg, .mideleg,
    .mpp, .spp, .mode, .nextMode
  );

  privCsrFile u_privCsrFile (
    .clk, .reset, .trap, .mTrap, .sTrap, .mret(mretGo), .sret(sretGo), .mode,
    .cause, .tval, .instrAddr, .csrAddr, .csrWrite, .csrWdata, .csrRead,
    .extIntM, .timerIntM, .softIntM, .csrRdata, .csrValid,
    .mtvec, .stvec, .mepc, .sepc, .mie, .mip, .medeleg, .mideleg,
    .statusMie, .statusSie, .mpp, .spp
  );

  csrAxiLite u_csrAxiLite (
    .clk, .reset, .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
    .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready,
    .csrRdata, .csrValid, .csrAddr, .csrWrite, .csrWdata, .csrRead
  );

endmodule

`default_nettype wire

// File: csrAxiLite.sv
// AXI4-Lite slave that turns host reads and writes into single-cycle CSR strobes
`timescale 1ns/1ps
`default_nettype none

module csrAxiLite import privPkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic [XLEN-1:0] awaddr,
  input  logic            awvalid,
  output logic            awready,
  input  logic [XLEN-1:0] wdata,
  input  logic            wvalid,
  output logic            wready,
  output logic [1:0]      bresp,
  output logic            bvalid,
  input  logic            bready,
  input  logic [XLEN-1:0] araddr,
  input  logic            arvalid,
  output logic            arready,
  output logic [XLEN-1:0] rdata,
  output logic [1:0]      rresp,
  output logic            rvalid,
  input  logic            rready,
  input  logic [XLEN-1:0] csrRdata,
  input  logic            csrValid,
  output logic [11:0]     csrAddr,
  output logic            csrWrite,
  output logic [XLEN-1:0] csrWdata,
  output logic            csrRead
);

  logic wrAccept;
  logic rdAccept;

  //////////////////////////////////////////////////
  // Acceptance
  //////////////////////////////////////////////////
  // Address and data together, only with no response pending
  assign wrAccept = awvalid && wvalid && !bvalid;
  // Single CSR port, a write in the same cycle goes first
  assign rdAccept = arvalid && !rvalid && !wrAccept;
  assign awready  = wrAccept;
  assign wready   = wrAccept;
  assign arready  = rdAccept;

  // CSR number sits in address bits 13 to 2
  assign csrAddr  = wrAccept ? awaddr[13:2] : araddr[13:2];
  assign csrWrite = wrAccept;
  assign csrWdata = wdata;
  assign csrRead  = rdAccept;

  // Response valid flags
  always_ff @(posedge clk) begin
    if (reset) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      if (wrAccept)    bvalid <= 1'b1;
      else if (bready) bvalid <= 1'b0;
      if (rdAccept)    rvalid <= 1'b1;
      else if (rready) rvalid <= 1'b0;
    end
  end

  // Response payload, held until the next accept
  always_ff @(posedge clk) begin
    if (wrAccept) bresp <= csrValid ? respOkay : respSlvErr;
    if (rdAccept) begin
      rdata <= csrRdata;
      rresp <= csrValid ? respOkay : respSlvErr;
    end
  end

  // Responses stay up, with stable data, until taken
  bHold: assert property (@(posedge clk) disable iff (reset) bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");
  rHold: assert property (@(posedge clk) disable iff (reset)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("read response changed before rready");

endmodule

`default_nettype wire

// File: privCsrFile.sv
// Trap CSR registers with trap and return updates and bus access by CSR number
`timescale 1ns/1ps
`default_nettype none

module privCsrFile import privPkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            trap,
  input  logic            mTrap,
  input  logic            sTrap,
  input  logic            mret,
  input  logic            sret,
  input  logic [1:0]      mode,
  input  logic [XLEN-1:0] cause,
  input  logic [XLEN-1:0] tval,
  input  logic [XLEN-1:0] instrAddr,
  input  logic [11:0]     csrAddr,
  input  logic            csrWrite,
  input  logic [XLEN-1:0] csrWdata,
  input  logic            csrRead,
  input  logic            extIntM,
  input  logic            timerIntM,
  input  logic            softIntM,
  output logic [XLEN-1:0] csrRdata,
  output logic            csrValid,
  output logic [XLEN-1:0] mtvec,
  output logic [XLEN-1:0] stvec,
  output logic [XLEN-1:0] mepc,
  output logic [XLEN-1:0] sepc,
  output logic [11:0]     mie,
  output logic [11:0]     mip,
  output logic [XLEN-1:0] medeleg,
  output logic [XLEN-1:0] mideleg,
  output logic            statusMie,
  output logic            statusSie,
  output logic [1:0]      mpp,
  output logic            spp
);

  logic            statusMpie;
  logic            statusSpie;
  logic [11:0]     sip;
  logic [XLEN-1:0] mcause;
  logic [XLEN-1:0] scause;
  logic [XLEN-1:0] mtval;
  logic [XLEN-1:0] stval;
  logic [XLEN-1:0] mstatusVal;
  logic [XLEN-1:0] sstatusVal;
  logic [XLEN-1:0] readVal;

  // M bits come straight from the interrupt lines, S bits from software
  assign mip = {extIntM, 3'b000, timerIntM, 3'b000, softIntM, 3'b000} | sip;

  // Status images, sstatus only shows the S fields
  assign mstatusVal = {{(XLEN-13){1'b0}}, mpp, 2'b00, spp, statusMpie, 1'b0,
                       statusSpie, 1'b0, statusMie, 1'b0, statusSie, 1'b0};
  assign sstatusVal = {{(XLEN-9){1'b0}}, spp, 2'b00, statusSpie, 3'b000, statusSie, 1'b0};

  //////////////////////////////////////////////////
  // Control state
  //////////////////////////////////////////////////
  // Trap and return updates come last so they win over a bus write
  always_ff @(posedge clk) begin
    if (reset) begin
      statusMie  <= 1'b0;
      statusSie  <= 1'b0;
      statusMpie <= 1'b0;
      statusSpie <= 1'b0;
      mpp        <= modeU;
      spp        <= 1'b0;
      medeleg    <= '0;
      mideleg    <= '0;
      mie        <= '0;
      sip        <= '0;
      mcause     <= '0;
      scause     <= '0;
    end else begin
      if (csrWrite) begin
        case (csrAddr)
          csrMstatus: begin
            statusSie  <= csrWdata[1];
            statusMie  <= csrWdata[3];
            statusSpie <= csrWdata[5];
            statusMpie <= csrWdata[7];
            spp        <= csrWdata[8];
            // Reserved MPP value is ignored
            if (csrWdata[12:11] != 2'b10) mpp <= csrWdata[12:11];
          end
          csrSstatus: begin
            statusSie  <= csrWdata[1];
            statusSpie <= csrWdata[5];
            spp        <= csrWdata[8];
          end
          csrMedeleg: medeleg <= csrWdata;
          // Only supervisor interrupts can be delegated
          csrMideleg: mideleg <= csrWdata & XLEN'(sIntMask);
          csrMie:     mie     <= csrWdata[11:0] & (mIntMask | sIntMask);
          csrMip:     sip     <= csrWdata[11:0] & sIntMask;
          csrMcause:  mcause  <= csrWdata;
          csrScause:  scause  <= csrWdata;
          default: ;
        endcase
      end
      if (trap) begin
        if (mTrap) begin
          mcause     <= cause;
          statusMpie <= statusMie;
          statusMie  <= 1'b0;
          mpp        <= mode;
        end
        if (sTrap) begin
          scause     <= cause;
          statusSpie <= statusSie;
          statusSie  <= 1'b0;
          spp        <= mode[0];
        end
      end else if (mret) begin
        statusMie  <= statusMpie;
        statusMpie <= 1'b1;
        mpp        <= modeU;
      end else if (sret) begin
        statusSie  <= statusSpie;
        statusSpie <= 1'b1;
        spp        <= 1'b0;
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (csrWrite) begin
      case (csrAddr)
        // Direct mode only, word aligned
        csrMtvec: mtvec <= {csrWdata[XLEN-1:2], 2'b00};
        csrStvec: stvec <= {csrWdata[XLEN-1:2], 2'b00};
        csrMepc:  mepc  <= {csrWdata[XLEN-1:2], 2'b00};
        csrSepc:  sepc  <= {csrWdata[XLEN-1:2], 2'b00};
        csrMtval: mtval <= csrWdata;
        csrStval: stval <= csrWdata;
        default: ;
      endcase
    end
    if (mTrap) begin
      mepc  <= instrAddr;
      mtval <= tval;
    end
    if (sTrap) begin
      sepc  <= instrAddr;
      stval <= tval;
    end
  end

  //////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////
  always_comb begin
    readVal  = '0;
    csrValid = 1'b1;
    case (csrAddr)
      csrMstatus: readVal = mstatusVal;
      csrSstatus: readVal = sstatusVal;
      csrMedeleg: readVal = medeleg;
      csrMideleg: readVal = mideleg;
      csrMie:     readVal = XLEN'(mie);
      csrMip:     readVal = XLEN'(mip);
      csrMtvec:   readVal = mtvec;
      csrStvec:   readVal = stvec;
      csrMepc:    readVal = mepc;
      csrSepc:    readVal = sepc;
      csrMcause:  readVal = mcause;
      csrScause:  readVal = scause;
      csrMtval:   readVal = mtval;
      csrStval:   readVal = stval;
      default:    csrValid = 1'b0;
    endcase
  end

  // Data only on a read strobe
  assign csrRdata = csrRead ? readVal : '0;

endmodule

`default_nettype wire

// File: trapRoute.sv
// Privilege mode register and the delegation choice of the mode a trap enters
`timescale 1ns/1ps
`default_nettype none

module trapRoute import privPkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            trap,
  input  logic            ret,
  input  logic            mret,
  input  logic [XLEN-1:0] cause,
  input  logic [XLEN-1:0] medeleg,
  input  logic [XLEN-1:0] mideleg,
  input  logic [1:0]      mpp,
  input  logic            spp,
  output logic [1:0]      mode,
  output logic [1:0]      nextMode
);

  logic [XLEN-1:0] delegReg;
  logic            delegated;

  // Interrupts look in mideleg, exceptions in medeleg
  assign delegReg  = cause[XLEN-1] ? mideleg : medeleg;
  // Traps taken in M never drop to S
  assign delegated = (mode != modeM) && delegReg[cause[4:0]];
  assign nextMode  = delegated ? modeS : modeM;

  //////////////////////////////////////////////////
  // Current privilege mode
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      mode <= modeM;
    end else if (trap) begin
      mode <= nextMode;
    end else if (ret) begin
      // sret gives S or U from the single SPP bit
      mode <= mret ? mpp : {1'b0, spp};
    end
  end

  // MPP is WARL in the CSR file so the reserved code never reaches mode
  modeLegal: assert property (@(posedge clk) disable iff (reset) mode != 2'b10)
    else $error("reserved privilege mode");

endmodule

`default_nettype wire

// File: trapCause.sv
// Trap decision picking the highest priority interrupt or exception, its tval and the redirect PC
`timescale 1ns/1ps
`default_nettype none

module trapCause import privPkg::*; (
  input  logic                  reset,
  input  logic                  retire,
  input  logic [faultCount-1:0] faults,
  input  logic                  mret,
  input  logic                  sret,
  input  logic [1:0]            mode,
  input  logic [1:0]            nextMode,
  input  logic [11:0]           mip,
  input  logic [11:0]           mie,
  input  logic                  statusMie,
  input  logic                  statusSie,
  input  logic [XLEN-1:0]       instrAddr,
  input  logic [XLEN-1:0]       dataAddr,
  input  logic [31:0]           instr,
  input  logic [XLEN-1:0]       mtvec,
  input  logic [XLEN-1:0]       stvec,
  input  logic [XLEN-1:0]       mepc,
  input  logic [XLEN-1:0]       sepc,
  output logic                  trap,
  output logic                  mTrap,
  output logic                  sTrap,
  output logic                  ret,
  output logic [XLEN-1:0]       cause,
  output logic [XLEN-1:0]       tval,
  output logic [XLEN-1:0]       redirectPc
);

  logic        mIntGlobalEn;
  logic        sIntGlobalEn;
  logic [11:0] globalMask;
  logic [11:0] pendingInts;
  logic        interrupt;

  //////////////////////////////////////////////////
  // Interrupt masking
  //////////////////////////////////////////////////
  // M interrupts always taken below M, S interrupts always taken in U
  assign mIntGlobalEn = (mode != modeM) || statusMie;
  assign sIntGlobalEn = (mode == modeU) || statusSie;
  assign globalMask   = ({12{mIntGlobalEn}} & mIntMask) | ({12{sIntGlobalEn}} & sIntMask);
  // Sampled only on a retiring instruction
  assign pendingInts  = {12{retire}} & mip & mie & globalMask;
  assign interrupt    = |pendingInts;

  // Trap and return strobes
  assign trap  = (retire && (|faults)) || interrupt;
  assign mTrap = trap && (nextMode == modeM);
  assign sTrap = trap && (nextMode == modeS);
  // A faulting return does not return
  assign ret   = retire && !trap && (mret || sret);

  //////////////////////////////////////////////////
  // Cause priority
  //////////////////////////////////////////////////
  always_comb begin
    // Interrupts first, machine before supervisor
    if      (pendingInts[irqMExt])              cause = causeIntFlag | XLEN'(irqMExt);
    else if (pendingInts[irqMSoft])             cause = causeIntFlag | XLEN'(irqMSoft);
    else if (pendingInts[irqMTimer])            cause = causeIntFlag | XLEN'(irqMTimer);
    else if (pendingInts[irqSExt])              cause = causeIntFlag | XLEN'(irqSExt);
    else if (pendingInts[irqSSoft])             cause = causeIntFlag | XLEN'(irqSSoft);
    else if (pendingInts[irqSTimer])            cause = causeIntFlag | XLEN'(irqSTimer);
    // Fetch side faults
    else if (faults[faultInstrPage])            cause = causeInstrPage;
    else if (faults[faultInstrAccess])          cause = causeInstrAccess;
    else if (faults[faultInstrMisaligned])      cause = causeInstrMisaligned;
    else if (faults[faultIllegal])              cause = causeIllegal;
    else if (faults[faultBreakpoint])           cause = causeBreakpoint;
    // Ecall code offset by the current mode
    else if (faults[faultEcall])                cause = causeEcallU + XLEN'(mode);
    // Data side faults
    else if (faults[faultLoadMisaligned])       cause = causeLoadMisaligned;
    else if (faults[faultStoreMisaligned])      cause = causeStoreMisaligned;
    else if (faults[faultLoadPage])             cause = causeLoadPage;
    else if (faults[faultStorePage])            cause = causeStorePage;
    else if (faults[faultLoadAccess])           cause = causeLoadAccess;
    else if (faults[faultStoreAccess])          cause = causeStoreAccess;
    else                                        cause = '0;
  end

  // Faulting address or instruction of the chosen cause
  // Interrupt causes carry the top bit and fall to zero
  always_comb begin
    case (cause)
      causeInstrMisaligned:                     tval = instrAddr;
      causeLoadMisaligned, causeStoreMisaligned: tval = dataAddr;
      causeIllegal:                             tval = XLEN'(instr);
      default:                                  tval = '0;
    endcase
  end

  // Return targets first, then the vector of the target mode
  always_comb begin
    if      (ret && mret)                       redirectPc = mepc;
    else if (ret && sret)                       redirectPc = sepc;
    else if (nextMode == modeS)                 redirectPc = stvec;
    else                                        redirectPc = mtvec;
  end

  // Routing must send every trap to exactly one of M or S
  always_comb begin
    if (!reset) begin
      assert (!trap || (mTrap ^ sTrap))
        else $error("trap not routed to exactly one mode");
    end
  end

endmodule

`default_nettype wire

// File: privPkg.sv
// Privilege package holding widths, mode codes, CSR numbers, interrupt masks and cause codes
`default_nettype none

package privPkg;

  // Register width
  localparam int XLEN = 32;

  // Privilege mode codes, 2'b10 is reserved
  localparam logic [1:0] modeU = 2'b00;
  localparam logic [1:0] modeS = 2'b01;
  localparam logic [1:0] modeM = 2'b11;

  //////////////////////////////////////////////////
  // CSR numbers
  //////////////////////////////////////////////////
  localparam logic [11:0] csrSstatus = 12'h100;
  localparam logic [11:0] csrStvec   = 12'h105;
  localparam logic [11:0] csrSepc    = 12'h141;
  localparam logic [11:0] csrScause  = 12'h142;
  localparam logic [11:0] csrStval   = 12'h143;
  localparam logic [11:0] csrMstatus = 12'h300;
  localparam logic [11:0] csrMedeleg = 12'h302;
  localparam logic [11:0] csrMideleg = 12'h303;
  localparam logic [11:0] csrMie     = 12'h304;
  localparam logic [11:0] csrMtvec   = 12'h305;
  localparam logic [11:0] csrMepc    = 12'h341;
  localparam logic [11:0] csrMcause  = 12'h342;
  localparam logic [11:0] csrMtval   = 12'h343;
  localparam logic [11:0] csrMip     = 12'h344;

  // Interrupt bit positions in mip and mie
  localparam int irqSSoft  = 1;
  localparam int irqMSoft  = 3;
  localparam int irqSTimer = 5;
  localparam int irqMTimer = 7;
  localparam int irqSExt   = 9;
  localparam int irqMExt   = 11;
  localparam logic [11:0] mIntMask = 12'h888;
  localparam logic [11:0] sIntMask = 12'h222;

  //////////////////////////////////////////////////
  // Cause codes
  //////////////////////////////////////////////////
  localparam logic [XLEN-1:0] causeInstrMisaligned = 0;
  localparam logic [XLEN-1:0] causeInstrAccess     = 1;
  localparam logic [XLEN-1:0] causeIllegal         = 2;
  localparam logic [XLEN-1:0] causeBreakpoint      = 3;
  localparam logic [XLEN-1:0] causeLoadMisaligned  = 4;
  localparam logic [XLEN-1:0] causeLoadAccess      = 5;
  localparam logic [XLEN-1:0] causeStoreMisaligned = 6;
  localparam logic [XLEN-1:0] causeStoreAccess     = 7;
  // Ecall from S and M follow at 9 and 11
  localparam logic [XLEN-1:0] causeEcallU          = 8;
  localparam logic [XLEN-1:0] causeInstrPage       = 12;
  localparam logic [XLEN-1:0] causeLoadPage        = 13;
  localparam logic [XLEN-1:0] causeStorePage       = 15;
  // Interrupt flag in the top cause bit
  localparam logic [XLEN-1:0] causeIntFlag = {1'b1, {(XLEN-1){1'b0}}};

  // Fault vector layout
  localparam int faultCount           = 12;
  localparam int faultInstrMisaligned = 0;
  localparam int faultInstrAccess     = 1;
  localparam int faultIllegal         = 2;
  localparam int faultBreakpoint      = 3;
  localparam int faultLoadMisaligned  = 4;
  localparam int faultStoreMisaligned = 5;
  localparam int faultLoadAccess      = 6;
  localparam int faultStoreAccess     = 7;
  localparam int faultEcall           = 8;
  localparam int faultInstrPage       = 9;
  localparam int faultLoadPage        = 10;
  localparam int faultStorePage       = 11;

  // AXI response codes
  localparam logic [1:0] respOkay   = 2'b00;
  localparam logic [1:0] respSlvErr = 2'b10;

endpackage

`default_nettype wire
